// ==== source/smc_lite_pkg.sv ====
// Size codes, controller state type, address and access count widths
package smc_lite_pkg;

   // --------------------------------------------------
   // Field widths
   // --------------------------------------------------
   localparam int addr_w       = 32;  // Host and external address
   localparam int num_access_w = 2;   // Accesses left in a request

   // A count of four wraps to zero in num_access_w bits
   localparam logic [num_access_w-1:0] last_access = 1;  // Count during final access

   // --------------------------------------------------
   // Transfer and bus size codes
   // --------------------------------------------------
   // Kept as a plain vector so the codes pack into decode keys
   typedef logic [1:0] size_t;

   localparam size_t size_8  = 2'b00;  // Byte
   localparam size_t size_16 = 2'b01;  // Halfword
   localparam size_t size_32 = 2'b10;  // Word
   // Code 2'b11 unused and rejected by the request decoder

   // --------------------------------------------------
   // Controller state
   // --------------------------------------------------
   typedef enum logic [1:0]
   {
      smc_idle = 2'b00,  // No access in progress
      smc_rw   = 2'b01   // External read or write access
   } smc_state_t;

endpackage

// ==== source/smc_request_decode.sv ====
// Host request decoder with bank window check, alignment check and size store
`timescale 1ns/1ps

module smc_request_decode
#(
   parameter logic [smc_lite_pkg::addr_w-1:0] bank_base = 32'h1000_0000,
   parameter logic [smc_lite_pkg::addr_w-1:0] bank_mask = 32'hF000_0000
)
(
   input  logic                            sys_clk25,
   input  logic                            n_sys_reset25,
   input  logic                            req,            // One-cycle host strobe
   input  logic [smc_lite_pkg::addr_w-1:0] req_addr,
   input  smc_lite_pkg::size_t             req_xfer_size,
   input  logic                            smc_busy,       // Access in progress
   output logic                            valid_access,   // Accepted request
   output smc_lite_pkg::size_t             v_xfer_size,    // Size qualified by valid_access
   output logic                            smc_decode_err  // Rejected request pulse
);

   logic                in_bank;      // Hits bank window
   logic                aligned;      // Address fits size
   logic                new_req;      // Strobe while idle
   smc_lite_pkg::size_t r_xfer_size;  // Size of request in progress

   assign in_bank = (req_addr & bank_mask) == bank_base;

   // Alignment per transfer size
   always_comb
   begin
      case (req_xfer_size)
         smc_lite_pkg::size_8:  aligned = 1'b1;
         smc_lite_pkg::size_16: aligned = ~req_addr[0];
         smc_lite_pkg::size_32: aligned = (req_addr[1:0] == 2'b00);
         default:               aligned = 1'b0;  // Unused code
      endcase
   end

   assign new_req      = req & ~smc_busy;  // Strobes while busy are dropped
   assign valid_access = new_req & in_bank & aligned;

   // --------------------------------------------------
   // Error pulse and size store
   // --------------------------------------------------
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         smc_decode_err <= 1'b0;
      else
         smc_decode_err <= new_req & ~(in_bank & aligned);  // High for one cycle only
   end

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         r_xfer_size <= smc_lite_pkg::size_8;
      else if (valid_access)
         r_xfer_size <= req_xfer_size;
   end

   // Incoming size on the accept cycle and stored size after it
   assign v_xfer_size = valid_access ? req_xfer_size : r_xfer_size;

   // Accepted request starts an access on the next cycle
   assert property (@(posedge sys_clk25) disable iff (!n_sys_reset25)
                    valid_access |=> smc_busy);

endmodule

// ==== source/smc_access_counter.sv ====
// Access counter loaded per request and stepped on each access done
`timescale 1ns/1ps

module smc_access_counter
#(
   parameter smc_lite_pkg::size_t bus_size = smc_lite_pkg::size_8
)
(
   input  logic                                  sys_clk25,
   input  logic                                  n_sys_reset25,
   input  logic                                  valid_access,
   input  smc_lite_pkg::size_t                   v_xfer_size,
   input  logic                                  smc_done,      // End of one access
   output logic [smc_lite_pkg::num_access_w-1:0] r_num_access   // Accesses left
);

   logic [smc_lite_pkg::num_access_w-1:0] load_count;  // Count for new request
   logic                                  r_active;    // Request in progress

   // Transfer width over bus width
   always_comb
   begin
      case ({v_xfer_size, bus_size})
         {smc_lite_pkg::size_32, smc_lite_pkg::size_8}:
            load_count = '0;  // Four accesses
         {smc_lite_pkg::size_32, smc_lite_pkg::size_16},
         {smc_lite_pkg::size_16, smc_lite_pkg::size_8}:
            load_count = 2'd2;
         default:
            load_count = smc_lite_pkg::last_access;  // Fits the bus in one access
      endcase
   end

   // --------------------------------------------------
   // Count register
   // --------------------------------------------------
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         r_num_access <= '0;
         r_active     <= 1'b0;
      end
      else if (valid_access)
      begin
         r_num_access <= load_count;
         r_active     <= 1'b1;
      end
      else if (smc_done && r_active)
      begin
         r_num_access <= r_num_access - 1'b1;  // Four wraps 0 -> 3
         if (r_num_access == smc_lite_pkg::last_access)
            r_active <= 1'b0;  // Final access finished
      end
   end

   // State machine only completes accesses of an accepted request
   assert property (@(posedge sys_clk25) disable iff (!n_sys_reset25)
                    smc_done |-> r_active);

endmodule

// ==== source/smc_state_machine.sv ====
// Access FSM with wait-state counter, done strobe, busy and write enable
`timescale 1ns/1ps

module smc_state_machine
#(
   parameter logic [3:0] wait_states = 4'd2
)
(
   input  logic                                  sys_clk25,
   input  logic                                  n_sys_reset25,
   input  logic                                  valid_access,
   input  logic                                  req_write,
   input  logic [smc_lite_pkg::num_access_w-1:0] r_num_access,
   output smc_lite_pkg::smc_state_t              smc_nextstate,
   output logic                                  smc_done,      // Last cycle of an access
   output logic                                  smc_busy,
   output logic                                  smc_n_we       // Active low write enable
);

   smc_lite_pkg::smc_state_t r_state;     // Current state
   logic [3:0]               r_wait_cnt;  // Cycles spent in this access
   logic                     r_write;     // Stored write flag
   logic                     v_write;     // Write flag qualified by valid_access

   assign smc_done = (r_state == smc_lite_pkg::smc_rw) && (r_wait_cnt == wait_states);

   // --------------------------------------------------
   // Next state
   // --------------------------------------------------
   always_comb
   begin
      case (r_state)
         smc_lite_pkg::smc_idle:
            smc_nextstate = valid_access ? smc_lite_pkg::smc_rw : smc_lite_pkg::smc_idle;
         smc_lite_pkg::smc_rw:
            if (smc_done && (r_num_access == smc_lite_pkg::last_access))
               smc_nextstate = smc_lite_pkg::smc_idle;  // Final access ends
            else
               smc_nextstate = smc_lite_pkg::smc_rw;
         default:
            smc_nextstate = smc_lite_pkg::smc_idle;
      endcase
   end

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         r_state  <= smc_lite_pkg::smc_idle;
         smc_busy <= 1'b0;
      end
      else
      begin
         r_state  <= smc_nextstate;
         smc_busy <= (smc_nextstate == smc_lite_pkg::smc_rw);
      end
   end

   // Wait-state count restarts at each access boundary
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         r_wait_cnt <= 4'd0;
      else if (smc_done)
         r_wait_cnt <= 4'd0;
      else if (r_state == smc_lite_pkg::smc_rw)
         r_wait_cnt <= r_wait_cnt + 4'd1;
   end

   // --------------------------------------------------
   // Write enable
   // --------------------------------------------------
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         r_write <= 1'b0;
      else if (valid_access)
         r_write <= req_write;
   end

   assign v_write = valid_access ? req_write : r_write;

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         smc_n_we <= 1'b1;
      else
         smc_n_we <= ~((smc_nextstate == smc_lite_pkg::smc_rw) & v_write);  // Tracks cs window
   end

endmodule

// ==== source/smc_addr_lite.sv ====
// External address, chip select and byte enable registers with lane decode
`timescale 1ns/1ps

module smc_addr_lite
#(
   parameter smc_lite_pkg::size_t bus_size = smc_lite_pkg::size_8
)
(
   input  logic                                  sys_clk25,
   input  logic                                  n_sys_reset25,
   input  logic                                  valid_access,   // Start of new request
   input  logic [smc_lite_pkg::num_access_w-1:0] r_num_access,   // Accesses left
   input  smc_lite_pkg::size_t                   v_xfer_size,
   input  logic [smc_lite_pkg::addr_w-1:0]       req_addr,
   input  logic                                  smc_done,       // Access complete
   input  smc_lite_pkg::smc_state_t              smc_nextstate,
   output logic [smc_lite_pkg::addr_w-1:0]       smc_addr,       // External address
   output logic [3:0]                            smc_n_be,       // External byte enables
   output logic                                  smc_n_cs        // External chip select
);

   logic [1:0] r_addr;   // Stored request low bits
   logic [1:0] v_addr;   // Low bits qualified by valid_access
   logic [3:0] n_be;     // Unregistered byte enables
   logic       rw_next;  // Access cycle follows

   assign rw_next = (smc_nextstate == smc_lite_pkg::smc_rw);

   // --------------------------------------------------
   // Low address bit store
   // --------------------------------------------------
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         r_addr <= 2'b00;
      else if (valid_access)
         r_addr <= req_addr[1:0];
   end

   assign v_addr = valid_access ? req_addr[1:0] : r_addr;

   // --------------------------------------------------
   // External address
   // --------------------------------------------------
   // Little endian only, highest lane goes out first
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
         smc_addr <= '0;
      else if (valid_access)
      begin
         smc_addr[smc_lite_pkg::addr_w-1:2] <= req_addr[smc_lite_pkg::addr_w-1:2];
         case ({v_xfer_size, bus_size})
            {smc_lite_pkg::size_32, smc_lite_pkg::size_32}:
               smc_addr[1:0] <= 2'b00;
            {smc_lite_pkg::size_32, smc_lite_pkg::size_16}:
               smc_addr[1:0] <= 2'b10;                  // Upper half first
            {smc_lite_pkg::size_32, smc_lite_pkg::size_8}:
               smc_addr[1:0] <= 2'b11;                  // Top byte first
            {smc_lite_pkg::size_16, smc_lite_pkg::size_32},
            {smc_lite_pkg::size_16, smc_lite_pkg::size_16}:
               smc_addr[1:0] <= {req_addr[1], 1'b0};
            {smc_lite_pkg::size_16, smc_lite_pkg::size_8}:
               smc_addr[1:0] <= {req_addr[1], 1'b1};    // Odd byte first
            default:
               smc_addr[1:0] <= req_addr[1:0];          // Byte transfers as issued
         endcase
      end
      else if (smc_done && (r_num_access != smc_lite_pkg::last_access))
      begin
         // Step down to the next lane, upper bits hold
         case ({v_xfer_size, bus_size})
            {smc_lite_pkg::size_32, smc_lite_pkg::size_16}:
               smc_addr[1:0] <= 2'b00;
            {smc_lite_pkg::size_32, smc_lite_pkg::size_8}:
               case (r_num_access)
                  2'b00:   smc_addr[1:0] <= 2'b10;      // Four left
                  2'b11:   smc_addr[1:0] <= 2'b01;
                  default: smc_addr[1:0] <= 2'b00;
               endcase
            {smc_lite_pkg::size_16, smc_lite_pkg::size_8}:
               smc_addr[1:0] <= {r_addr[1], 1'b0};
            default:
               smc_addr[1:0] <= smc_addr[1:0];
         endcase
      end
   end

   // --------------------------------------------------
   // Byte lane decode
   // --------------------------------------------------
   always_comb
   begin
      case (bus_size)
         smc_lite_pkg::size_8:  n_be = 4'b1110;  // Lane 0 only
         smc_lite_pkg::size_16: n_be = 4'b1100;  // Lanes 1 and 0
         smc_lite_pkg::size_32:
            case (v_xfer_size)
               smc_lite_pkg::size_8:  n_be = ~(4'b0001 << v_addr);       // Lane from address
               smc_lite_pkg::size_16: n_be = v_addr[1] ? 4'b0011 : 4'b1100;
               smc_lite_pkg::size_32: n_be = 4'b0000;
               default:               n_be = 4'b1111;  // Invalid decode
            endcase
         default: n_be = 4'b1111;
      endcase
   end

   // Chip select and lanes only during access cycles
   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         smc_n_be <= 4'hF;
         smc_n_cs <= 1'b1;
      end
      else
      begin
         smc_n_be <= rw_next ? n_be : 4'hF;
         smc_n_cs <= ~rw_next;  // Single bank
      end
   end

   assert property (@(posedge sys_clk25) disable iff (!n_sys_reset25)
                    !smc_n_cs |-> (smc_n_be != 4'hF));

endmodule

// ==== source/smc_lite_top.sv ====
// Static memory controller top with decoder, counter, FSM and address block
`timescale 1ns/1ps

module smc_lite_top
#(
   parameter logic [smc_lite_pkg::addr_w-1:0] bank_base   = 32'h1000_0000,
   parameter logic [smc_lite_pkg::addr_w-1:0] bank_mask   = 32'hF000_0000,
   parameter smc_lite_pkg::size_t             bus_size    = smc_lite_pkg::size_8,
   parameter logic [3:0]                      wait_states = 4'd2
)
(
   input  logic                            sys_clk25,
   input  logic                            n_sys_reset25,
   input  logic                            req,
   input  logic [smc_lite_pkg::addr_w-1:0] req_addr,
   input  smc_lite_pkg::size_t             req_xfer_size,
   input  logic                            req_write,
   output logic [smc_lite_pkg::addr_w-1:0] smc_addr,
   output logic                            smc_n_cs,
   output logic [3:0]                      smc_n_be,
   output logic                            smc_n_we,
   output logic                            smc_busy,
   output logic                            smc_decode_err
);

   logic                                  valid_access;
   smc_lite_pkg::size_t                   v_xfer_size;
   logic [smc_lite_pkg::num_access_w-1:0] r_num_access;
   smc_lite_pkg::smc_state_t              smc_nextstate;
   logic                                  smc_done;

   // --------------------------------------------------
   // Request front end
   // --------------------------------------------------
   smc_request_decode #(.bank_base(bank_base), .bank_mask(bank_mask)) u_decode
   (
      .sys_clk25      (sys_clk25),
      .n_sys_reset25  (n_sys_reset25),
      .req            (req),
      .req_addr       (req_addr),
      .req_xfer_size  (req_xfer_size),
      .smc_busy       (smc_busy),
      .valid_access   (valid_access),
      .v_xfer_size    (v_xfer_size),
      .smc_decode_err (smc_decode_err)
   );

   smc_access_counter #(.bus_size(bus_size)) u_counter
   (
      .sys_clk25     (sys_clk25),
      .n_sys_reset25 (n_sys_reset25),
      .valid_access  (valid_access),
      .v_xfer_size   (v_xfer_size),
      .smc_done      (smc_done),
      .r_num_access  (r_num_access)
   );

   // --------------------------------------------------
   // Access sequencing and external pins
   // --------------------------------------------------
   smc_state_machine #(.wait_states(wait_states)) u_fsm
   (
      .sys_clk25     (sys_clk25),
      .n_sys_reset25 (n_sys_reset25),
      .valid_access  (valid_access),
      .req_write     (req_write),
      .r_num_access  (r_num_access),
      .smc_nextstate (smc_nextstate),
      .smc_done      (smc_done),
      .smc_busy      (smc_busy),
      .smc_n_we      (smc_n_we)
   );

   smc_addr_lite #(.bus_size(bus_size)) u_addr
   (
      .sys_clk25     (sys_clk25),
      .n_sys_reset25 (n_sys_reset25),
      .valid_access  (valid_access),
      .r_num_access  (r_num_access),
      .v_xfer_size   (v_xfer_size),
      .req_addr      (req_addr),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs)
   );

endmodule

// ==== test/smc_lite_tb.sv ====
// Testbench with clock, reset, stimulus reader, access monitor, check task and watchdog
`timescale 1ns/1ps

module smc_lite_tb;

   localparam smc_lite_pkg::size_t bus_size      = smc_lite_pkg::size_8;
   localparam logic [3:0]          wait_states   = 4'd2;
   localparam int                  access_cycles = int'(wait_states) + 1;  // Per access
   localparam int                  num_random    = 16;

   logic                sys_clk25;
   logic                n_sys_reset25;
   logic                req;
   logic [31:0]         req_addr;
   smc_lite_pkg::size_t req_xfer_size;
   logic                req_write;
   logic [31:0]         smc_addr;
   logic                smc_n_cs;
   logic [3:0]          smc_n_be;
   logic                smc_n_we;
   logic                smc_busy;
   logic                smc_decode_err;

   int          error_count = 0;
   int          num_tests   = 0;   // Sizes the watchdog
   int          cs_cycles   = 0;   // Chip select low cycles in this request
   int          err_cycles  = 0;   // Decode error cycles in this request
   logic [31:0] seen_addr[$];      // One entry per access
   logic [3:0]  seen_be[$];
   logic        seen_we[$];
   logic [31:0] st_addr[$];        // File columns
   logic [31:0] st_size[$];
   logic [31:0] st_write[$];
   logic [31:0] st_err[$];
   logic [31:0] st_count[$];
   logic [31:0] seed = 32'd26;

   smc_lite_top #(.bank_base(32'h1000_0000), .bank_mask(32'hF000_0000),
                  .bus_size(bus_size), .wait_states(wait_states)) dut
   (
      .sys_clk25(sys_clk25), .n_sys_reset25(n_sys_reset25), .req(req),
      .req_addr(req_addr), .req_xfer_size(req_xfer_size), .req_write(req_write),
      .smc_addr(smc_addr), .smc_n_cs(smc_n_cs), .smc_n_be(smc_n_be),
      .smc_n_we(smc_n_we), .smc_busy(smc_busy), .smc_decode_err(smc_decode_err)
   );

   initial
   begin
      sys_clk25 = 1'b0;
      forever #4 sys_clk25 = ~sys_clk25;  // 8 ns period
   end

   // --------------------------------------------------
   // Reference rules
   // --------------------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // Transfer width over bus width, at least one
   function automatic int access_count(input smc_lite_pkg::size_t size);
      int n;
      n = (1 << size) / (1 << bus_size);
      return (n < 1) ? 1 : n;
   endfunction

   function automatic logic [31:0] expected_addr(input logic [31:0] addr,
                                                 input smc_lite_pkg::size_t size, input int idx);
      logic [1:0] low;
      if (size == smc_lite_pkg::size_32 && bus_size == smc_lite_pkg::size_8)
         low = 2'(3 - idx);                           // 11, 10, 01, 00
      else if (size == smc_lite_pkg::size_32 && bus_size == smc_lite_pkg::size_16)
         low = (idx == 0) ? 2'b10 : 2'b00;
      else if (size == smc_lite_pkg::size_16 && bus_size == smc_lite_pkg::size_8)
         low = {addr[1], idx == 0};                   // Odd byte first
      else if (size == smc_lite_pkg::size_32)
         low = 2'b00;
      else if (size == smc_lite_pkg::size_16)
         low = {addr[1], 1'b0};
      else
         low = addr[1:0];
      return {addr[31:2], low};
   endfunction

   function automatic logic [3:0] expected_be(input logic [31:0] addr,
                                              input smc_lite_pkg::size_t size);
      if (bus_size == smc_lite_pkg::size_8)
         return 4'b1110;                              // Lane 0
      else if (bus_size == smc_lite_pkg::size_16)
         return 4'b1100;
      else if (size == smc_lite_pkg::size_8)
         return ~(4'b0001 << addr[1:0]);
      else if (size == smc_lite_pkg::size_16)
         return addr[1] ? 4'b0011 : 4'b1100;          // Half from bit 1
      else
         return 4'b0000;
   endfunction

   // --------------------------------------------------
   // Reporting
   // --------------------------------------------------
   task automatic abort_run(input string reason);
      error_count++;
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
         abort_run($sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
   endtask

   task automatic read_stimulus();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] f_addr;
      logic [31:0] f_size;
      logic [31:0] f_write;
      logic [31:0] f_err;
      logic [31:0] f_count;
      fd = $fopen("test/smc_lite_stimulus.txt", "r");
      if (fd == 0)
         abort_run("Could not open the stimulus file test/smc_lite_stimulus.txt");
      else
      begin
         while (!$feof(fd))
         begin
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
            begin
               fields = $sscanf(line, "%h %h %h %h %h", f_addr, f_size, f_write, f_err, f_count);
               if (fields != 5)
                  abort_run($sformatf("Stimulus line could not be parsed: %s", line));
               else
               begin
                  st_addr.push_back(f_addr);
                  st_size.push_back(f_size);
                  st_write.push_back(f_write);
                  st_err.push_back(f_err);
                  st_count.push_back(f_count);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // --------------------------------------------------
   // One request plus a strobe while busy
   // --------------------------------------------------
   task automatic run_request(input string name, input logic [31:0] addr,
                              input smc_lite_pkg::size_t size, input logic write,
                              input logic exp_err, input int exp_count);
      int   wait_count;
      logic exp_we;
      seen_addr.delete();
      seen_be.delete();
      seen_we.delete();
      cs_cycles  = 0;
      err_cycles = 0;
      wait_count = 0;
      exp_we     = ~write;
      @(posedge sys_clk25);
      #1;
      req           = 1'b1;
      req_addr      = addr;
      req_xfer_size = size;
      req_write     = write;
      @(posedge sys_clk25);
      #1;
      if (exp_err)
         req = 1'b0;
      else
      begin
         req_addr      = addr ^ 32'h8000_0001;  // Outside bank, must be dropped
         req_xfer_size = smc_lite_pkg::size_8;
         req_write     = ~write;
      end
      @(posedge sys_clk25);
      #1;
      req = 1'b0;
      while (smc_busy)
      begin
         if (wait_count > 4 * 16)
            abort_run($sformatf("Busy never dropped during %s", name));
         else
         begin
            @(posedge sys_clk25);
            #1;
            wait_count++;
         end
      end
      repeat (2) @(posedge sys_clk25);  // Let the monitor see the idle cycles
      check_value({name, " decode error cycles"}, 32'(exp_err), 32'(err_cycles));
      check_value({name, " access count"}, 32'(exp_count), 32'(seen_addr.size()));
      check_value({name, " chip select cycles"}, 32'(exp_count * access_cycles), 32'(cs_cycles));
      for (int i = 0; i < exp_count; i++)
      begin
         check_value($sformatf("%s address %0d", name, i), expected_addr(addr, size, i),
                     seen_addr[i]);
         check_value($sformatf("%s lanes %0d", name, i), 32'(expected_be(addr, size)),
                     32'(seen_be[i]));
         check_value($sformatf("%s write enable %0d", name, i), 32'(exp_we), 32'(seen_we[i]));
      end
   endtask

   // Samples at the falling edge, away from register updates
   always @(negedge sys_clk25)
   begin
      if (n_sys_reset25)
      begin
         check_value("busy follows chip select", 32'(!smc_n_cs), 32'(smc_busy));
         if (smc_decode_err)
            err_cycles++;
         if (!smc_n_cs)
         begin
            if (cs_cycles % access_cycles == 0)  // First cycle of an access
            begin
               seen_addr.push_back(smc_addr);
               seen_be.push_back(smc_n_be);
               seen_we.push_back(smc_n_we);
            end
            cs_cycles++;
         end
         else
         begin
            check_value("lanes idle outside chip select", 32'hF, 32'(smc_n_be));
            check_value("write enable idle outside chip select", 32'd1, 32'(smc_n_we));
         end
      end
   end

   initial
   begin
      logic [31:0]         r_addr;
      logic [31:0]         r_pick;
      smc_lite_pkg::size_t r_size;
      n_sys_reset25 = 1'b0;
      req           = 1'b0;
      req_addr      = 32'h0;
      req_xfer_size = smc_lite_pkg::size_8;
      req_write     = 1'b0;
      read_stimulus();
      num_tests = st_addr.size() + num_random;
      repeat (8) @(posedge sys_clk25);
      #1;
      n_sys_reset25 = 1'b1;
      repeat (4)
      begin
         @(negedge sys_clk25);
         check_value("reset chip select", 32'd1, 32'(smc_n_cs));
         check_value("reset decode error", 32'd0, 32'(smc_decode_err));
      end
      for (int i = 0; i < st_addr.size(); i++)
         run_request($sformatf("line %0d", i), st_addr[i], st_size[i][1:0], st_write[i][0],
                     st_err[i][0], int'(st_count[i]));
      for (int i = 0; i < num_random; i++)
      begin
         seed   = lcg_next(seed);
         r_addr = 32'h1000_0000 | (seed & 32'h0FFF_FFFF);  // Inside bank
         seed   = lcg_next(seed);
         r_pick = (seed >> 16) % 32'd3;
         r_size = r_pick[1:0];
         if (r_size == smc_lite_pkg::size_16)
            r_addr[0] = 1'b0;
         else if (r_size == smc_lite_pkg::size_32)
            r_addr[1:0] = 2'b00;
         run_request($sformatf("random %0d", i), r_addr, r_size, seed[24], 1'b0,
                     access_count(r_size));
      end
      if (error_count == 0)
      begin
         $display("All tests passed");
         $finish;
      end
      else
      begin
         $display("Some tests failed");
         $fatal(1, "Errors were recorded");
      end
   end

   // Up to 4 accesses of 16 cycles at 8 ns per request, plus reset margin
   initial
   begin
      wait (num_tests > 0);
      #(num_tests * 4 * 16 * 8 + 2000);
      abort_run("Timeout: the run did not finish in the expected time");
   end

endmodule

// ==== test/smc_lite_stimulus.txt ====
# addr size write exp_err exp_count, all hex, size 0=8 1=16 2=32 3=unused
# Bus is 8 bits wide, bank window 1000_0000 to 1FFF_FFFF
10000000 0 0 0 1
10000003 0 1 0 1
10000010 1 0 0 2
10000012 1 1 0 2
10000020 2 0 0 4
10000024 2 1 0 4
1FFFFFFC 2 1 0 4
1ABCDEF1 0 0 0 1
10000011 1 0 1 0
10000022 2 0 1 0
10000021 2 1 1 0
00000040 0 0 1 0
20000000 2 1 1 0
F0000000 1 0 1 0
10000040 3 0 1 0
10000100 2 0 0 4
1000FFFE 1 0 0 2
0FFFFFFF 0 1 1 0
1234567A 1 1 0 2
17654321 0 1 0 1
1C000008 2 0 0 4
30000004 2 0 1 0
10000007 1 1 1 0

// ==== smc_lite_top.f ====
source/smc_lite_pkg.sv
source/smc_request_decode.sv
source/smc_access_counter.sv
source/smc_state_machine.sv
source/smc_addr_lite.sv
source/smc_lite_top.sv
test/smc_lite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f smc_lite_top.f \
   --top-module smc_lite_tb -o smc_lite_sim || exit 1
./obj_dir/smc_lite_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
